/* arcade_io_pkg.sv */
//##########################################################################
// Shared types, memory map and depths of the arcade I/O block
// Imported by every RTL module and by the testbench
//##########################################################################
package arcade_io_pkg;

   // CPU bus and trackball sizes
   localparam int ADDR_W      = 10;
   localparam int AXIS_COUNT  = 4;
   localparam int TRACK_SEL_W = $clog2(AXIS_COUNT);

   // RAM depths and the index width of each
   localparam int NV_DEPTH    = 256;
   localparam int COLOR_DEPTH = 64;
   localparam int NV_AW       = $clog2(NV_DEPTH);
   localparam int COLOR_AW    = $clog2(COLOR_DEPTH);

   // Region bases on the CPU bus
   localparam logic [ADDR_W-1:0] NV_BASE    = 10'h000;
   localparam logic [ADDR_W-1:0] COLOR_BASE = 10'h100;
   localparam logic [ADDR_W-1:0] TRACK_BASE = 10'h180;

   // Region sizes in bytes
   // Color region covers both the low and the ninth-bit alias
   localparam logic [ADDR_W-1:0] NV_SPAN    = ADDR_W'(NV_DEPTH);
   localparam logic [ADDR_W-1:0] COLOR_SPAN = ADDR_W'(2 * COLOR_DEPTH);
   localparam logic [ADDR_W-1:0] TRACK_SPAN = ADDR_W'(AXIS_COUNT);

   // Address bit that selects the ninth-bit alias of a color entry
   localparam int COLOR_HI_BIT = 6;

   // Cycles from read strobe to response
   localparam int READ_LATENCY = 2;

   // Data words
   typedef logic [7:0] byte_t;
   typedef logic [8:0] color_word_t;

   // Value seen on reads of unmapped space
   localparam byte_t OPEN_BUS_DATA = 8'hFF;

   // CPU request, one-cycle strobe in valid
   typedef struct packed {
      logic              valid;
      logic              we;
      logic [ADDR_W-1:0] addr;
      byte_t             wdata;
   } bus_req_t;

   // Read response, valid for one cycle per read
   typedef struct packed {
      logic  valid;
      byte_t rdata;
   } bus_rsp_t;

   // Quadrature pins of one trackball axis
   typedef struct packed {
      logic a;
      logic b;
   } quad_pins_t;

   typedef quad_pins_t [AXIS_COUNT-1:0] axis_pins_t;

   // Decoded target of a bus address
   typedef enum logic [1:0] {
      REGION_NV,
      REGION_COLOR,
      REGION_TRACK,
      REGION_NONE
   } io_region_e;

endpackage

/* sync_ram.sv */
//##########################################################################
// Single-port synchronous RAM, payload type set per instance
// Read data registered one cycle after the address, held during writes
//##########################################################################
module sync_ram
#(
   parameter type word_t = logic [7:0],
   parameter int  DEPTH  = 256
)
(
   input  logic                     clk,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  word_t                    wdata,
   output word_t                    rdata
);

   // Storage array, contents unknown until written
   word_t mem [DEPTH];

   // Write port and registered read share the address
   // Read output keeps its last value on a write cycle
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[addr] <= wdata;
      end
      else
      begin
         rdata <= mem[addr];
      end
   end

endmodule

/* quad_decoder.sv */
//##########################################################################
// Quadrature decoder for one trackball axis
// Synchronizes the A/B pins and keeps a wrapping 8-bit position count
//##########################################################################
module quad_decoder
   import arcade_io_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  quad_pins_t pins,
   output byte_t      count
);

   // Pin history, stages 0 and 1 form the synchronizer
   logic [2:0] a_sr;
   logic [2:0] b_sr;
   logic       step;
   logic       dir;

   // Shift in the raw pins every clock
   // No reset needed, the history fills while reset is held
   always_ff @(posedge clk)
   begin
      a_sr <= {a_sr[1:0], pins.a};
      b_sr <= {b_sr[1:0], pins.b};
   end

   // One valid step when exactly one pin toggled
   assign step = a_sr[1] ^ a_sr[2] ^ b_sr[1] ^ b_sr[2];

   // New A against old B gives the direction
   // Sequence 00,10,11,01 counts up
   assign dir = a_sr[1] ^ b_sr[2];

   // Position counter, wraps at both ends
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         count <= '0;
      end
      else if (step)
      begin
         if (dir)
            count <= count + 8'd1;
         else
            count <= count - 8'd1;
      end
   end

endmodule

/* leta_bank.sv */
//##########################################################################
// Trackball interface with one quadrature counter per axis
// The selected axis count is registered every clock for the bus read path
//##########################################################################
module leta_bank
   import arcade_io_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_n,
   input  axis_pins_t             trk,
   input  logic [TRACK_SEL_W-1:0] track_sel,
   output byte_t                  track_rdata
);

   // Live counts of all axes
   byte_t counts [AXIS_COUNT];

   // One decoder per axis
   genvar i;
   generate
      for (i = 0; i < AXIS_COUNT; i++)
      begin : g_axis
         quad_decoder quad_decoder_i
         (
            .clk     (clk),
            .reset_n (reset_n),
            .pins    (trk[i]),
            .count   (counts[i])
         );
      end
   endgenerate

   // Registered axis select
   // Data arrives one cycle after track_sel, in step with the RAMs
   always_ff @(posedge clk)
   begin
      track_rdata <= counts[track_sel];
   end

endmodule

/* io_bus_ctrl.sv */
//##########################################################################
// CPU bus decoder and read response pipeline of the I/O block
// Steers writes to the RAMs and answers each read two cycles later
//##########################################################################
module io_bus_ctrl
   import arcade_io_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset_n,
   input  bus_req_t               req,
   output bus_rsp_t               rsp,
   output logic                   nv_we,
   output logic [NV_AW-1:0]       nv_addr,
   output byte_t                  nv_wdata,
   input  byte_t                  nv_rdata,
   output logic                   color_we,
   output logic [COLOR_AW-1:0]    color_addr,
   output color_word_t            color_wdata,
   input  color_word_t            color_rdata,
   output logic [TRACK_SEL_W-1:0] track_sel,
   input  byte_t                  track_rdata
);

   // What stage 2 needs to know about a read in flight
   typedef struct packed {
      logic       valid;
      io_region_e region;
      logic       color_hi;
   } rd_tag_t;

   // Offsets of the address into each region
   logic [ADDR_W-1:0] nv_off;
   logic [ADDR_W-1:0] color_off;
   logic [ADDR_W-1:0] track_off;

   io_region_e region;
   logic       color_hi;
   logic       wr_valid;
   rd_tag_t    tag_s1;
   byte_t      rdata_mux;
   logic       rsp_valid_q;
   byte_t      rsp_rdata_q;

   // Offsets wrap below a base, so one compare per region
   assign nv_off    = req.addr - NV_BASE;
   assign color_off = req.addr - COLOR_BASE;
   assign track_off = req.addr - TRACK_BASE;

   // Region decode
   always_comb
   begin
      if (nv_off < NV_SPAN)
         region = REGION_NV;
      else if (color_off < COLOR_SPAN)
         region = REGION_COLOR;
      else if (track_off < TRACK_SPAN)
         region = REGION_TRACK;
      else
         region = REGION_NONE;
   end

   // Ninth-bit alias of the color region
   assign color_hi = req.addr[COLOR_HI_BIT];

   // Write strobes, RAM regions only
   // Trackball and unmapped writes are dropped
   assign wr_valid = req.valid & req.we;
   assign nv_we    = wr_valid & (region == REGION_NV);
   assign color_we = wr_valid & (region == REGION_COLOR);

   // RAM and trackball addresses follow the bus every cycle
   assign nv_addr    = nv_off[NV_AW-1:0];
   assign nv_wdata   = req.wdata;
   assign color_addr = color_off[COLOR_AW-1:0];
   assign track_sel  = track_off[TRACK_SEL_W-1:0];

   // High alias sets bit 8 from wdata bit 0 and clears the low byte
   // Low alias writes the low byte and clears bit 8
   assign color_wdata = color_hi ? {req.wdata[0], 8'h00} : {1'b0, req.wdata};

   // Stage 1, tag each read while the RAMs fetch
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         tag_s1 <= '0;
      end
      else
      begin
         tag_s1.valid    <= req.valid & ~req.we;
         tag_s1.region   <= region;
         tag_s1.color_hi <= color_hi;
      end
   end

   // Pick and shape the data of the read in stage 1
   always_comb
   begin
      case (tag_s1.region)
         REGION_NV:
            rdata_mux = nv_rdata;
         REGION_COLOR:
            // Ninth bit comes back in bit 0 on the high alias
            rdata_mux = tag_s1.color_hi ? {7'b0, color_rdata[8]} : color_rdata[7:0];
         REGION_TRACK:
            rdata_mux = track_rdata;
         default:
            rdata_mux = OPEN_BUS_DATA;
      endcase
   end

   // Stage 2 response valid
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
         rsp_valid_q <= 1'b0;
      else
         rsp_valid_q <= tag_s1.valid;
   end

   // Stage 2 response data, loaded only for reads
   always_ff @(posedge clk)
   begin
      if (tag_s1.valid)
         rsp_rdata_q <= rdata_mux;
   end

   assign rsp = '{valid: rsp_valid_q, rdata: rsp_rdata_q};

endmodule

/* arcade_io_top.sv */
//##########################################################################
// Memory-mapped I/O block of the arcade CPU board
// Bus decoder, settings NVRAM, color RAM and trackball counters
//##########################################################################
module arcade_io_top
   import arcade_io_pkg::*;
(
   input  logic       clk,
   input  logic       reset_n,
   input  bus_req_t   req,
   input  axis_pins_t trk,
   output bus_rsp_t   rsp
);

   // NVRAM port
   logic                   nv_we;
   logic [NV_AW-1:0]       nv_addr;
   byte_t                  nv_wdata;
   byte_t                  nv_rdata;

   // Color RAM port
   logic                   color_we;
   logic [COLOR_AW-1:0]    color_addr;
   color_word_t            color_wdata;
   color_word_t            color_rdata;

   // Trackball read path
   logic [TRACK_SEL_W-1:0] track_sel;
   byte_t                  track_rdata;

   io_bus_ctrl io_bus_ctrl_i
   (
      .clk         (clk),
      .reset_n     (reset_n),
      .req         (req),
      .rsp         (rsp),
      .nv_we       (nv_we),
      .nv_addr     (nv_addr),
      .nv_wdata    (nv_wdata),
      .nv_rdata    (nv_rdata),
      .color_we    (color_we),
      .color_addr  (color_addr),
      .color_wdata (color_wdata),
      .color_rdata (color_rdata),
      .track_sel   (track_sel),
      .track_rdata (track_rdata)
   );

   // 256 x 8 settings RAM
   sync_ram #(.word_t(byte_t), .DEPTH(NV_DEPTH)) nv_ram_i
   (
      .clk   (clk),
      .we    (nv_we),
      .addr  (nv_addr),
      .wdata (nv_wdata),
      .rdata (nv_rdata)
   );

   // 64 x 9 color RAM
   sync_ram #(.word_t(color_word_t), .DEPTH(COLOR_DEPTH)) color_ram_i
   (
      .clk   (clk),
      .we    (color_we),
      .addr  (color_addr),
      .wdata (color_wdata),
      .rdata (color_rdata)
   );

   leta_bank leta_bank_i
   (
      .clk         (clk),
      .reset_n     (reset_n),
      .trk         (trk),
      .track_sel   (track_sel),
      .track_rdata (track_rdata)
   );

endmodule

/* arcade_io_props.sv */
//##########################################################################
// Bus protocol assertions for io_bus_ctrl, attached with bind
//##########################################################################
module arcade_io_props
   import arcade_io_pkg::*;
(
   input logic     clk,
   input logic     reset_n,
   input bus_req_t req,
   input bus_rsp_t rsp,
   input logic     nv_we,
   input logic     color_we
);

   logic rd_strobe;

   assign rd_strobe = req.valid & ~req.we;

   // Every read answers after the fixed latency
   read_gets_response: assert property (@(posedge clk) disable iff (!reset_n)
      rd_strobe |-> ##READ_LATENCY rsp.valid)
   else $error("read strobe without a response after the read latency");

   // No response without a matching read strobe
   response_has_read: assert property (@(posedge clk) disable iff (!reset_n)
      rsp.valid |-> $past(rd_strobe, READ_LATENCY))
   else $error("response valid without a read strobe before it");

   // Each RAM strobe only for a bus write inside that RAM's address range
   // Disjoint ranges keep both strobes from being high together
   nv_write_in_range: assert property (@(posedge clk)
      nv_we |-> req.valid && req.we && req.addr < COLOR_BASE)
   else $error("NVRAM write strobe without a bus write to the NVRAM range");

   color_write_in_range: assert property (@(posedge clk)
      color_we |-> req.valid && req.we && req.addr >= COLOR_BASE && req.addr < TRACK_BASE)
   else $error("color RAM write strobe without a bus write to the color range");

   // Write strobes stay low in reset
   no_write_in_reset: assert property (@(posedge clk) !reset_n |-> !nv_we && !color_we)
   else $error("RAM write strobe high during reset");

endmodule

bind io_bus_ctrl arcade_io_props arcade_io_props_i
(
   .clk      (clk),
   .reset_n  (reset_n),
   .req      (req),
   .rsp      (rsp),
   .nv_we    (nv_we),
   .color_we (color_we)
);

/* arcade_io_tb.sv */
//##########################################################################
// Testbench of the arcade I/O block, random bus traffic and trackball motion
// Checks every read response against a model of the memory map
//##########################################################################
module arcade_io_tb
   import arcade_io_pkg::*;
();

   logic       clk;
   logic       reset_n;
   bus_req_t   req;
   axis_pins_t trk;
   bus_rsp_t   rsp;

   // Fixed seed keeps every run the same
   integer seed = 32'h170eedd3;

   // Reference model of the three targets
   byte_t       nv_model [NV_DEPTH];
   bit          nv_written [NV_DEPTH];
   color_word_t color_model [COLOR_DEPTH];
   bit          color_written [COLOR_DEPTH];
   byte_t       count_model [AXIS_COUNT];
   logic [1:0]  phase [AXIS_COUNT];
   axis_pins_t  trk_next;

   // Reads in flight, oldest first
   byte_t exp_q [$];
   bit    chk_q [$];
   int    strobe_q [$];

   // Negedge cycle count and the cycle of the last pin change
   int    cyc = 0;
   int    pin_cyc = 0;
   int    strobe_t;
   byte_t exp_v;
   bit    chk_v;

   arcade_io_top arcade_io_top_i
   (
      .clk     (clk),
      .reset_n (reset_n),
      .req     (req),
      .trk     (trk),
      .rsp     (rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   // Gray code of one axis, 00 10 11 01 is the up direction
   function automatic quad_pins_t pins_for_phase(input logic [1:0] ph);
      quad_pins_t p;
      case (ph)
         2'd0:    p = '{a: 1'b0, b: 1'b0};
         2'd1:    p = '{a: 1'b1, b: 1'b0};
         2'd2:    p = '{a: 1'b1, b: 1'b1};
         default: p = '{a: 1'b0, b: 1'b1};
      endcase
      return p;
   endfunction

   // Memory map rules for writes
   function automatic void apply_write_to_model(input logic [ADDR_W-1:0] addr, input byte_t data);
      if (addr < COLOR_BASE)
      begin
         nv_model[addr[7:0]]   = data;
         nv_written[addr[7:0]] = 1'b1;
      end
      else if (addr < TRACK_BASE)
      begin
         // High alias sets bit 8 and clears the low byte
         if (addr[COLOR_HI_BIT])
            color_model[addr[5:0]] = {data[0], 8'h00};
         else
            color_model[addr[5:0]] = {1'b0, data};
         color_written[addr[5:0]] = 1'b1;
      end
      // Trackball and unmapped writes change nothing
   endfunction

   // Expected read data, returns 0 for a never-written RAM cell
   function automatic bit expected_read(input logic [ADDR_W-1:0] addr, output byte_t value);
      value = OPEN_BUS_DATA;
      if (addr < COLOR_BASE)
      begin
         value = nv_model[addr[7:0]];
         return nv_written[addr[7:0]];
      end
      else if (addr < TRACK_BASE)
      begin
         if (addr[COLOR_HI_BIT])
            value = {7'b0, color_model[addr[5:0]][8]};
         else
            value = color_model[addr[5:0]][7:0];
         return color_written[addr[5:0]];
      end
      else if (addr < TRACK_BASE + ADDR_W'(AXIS_COUNT))
      begin
         value = count_model[addr[1:0]];
      end
      return 1'b1;
   endfunction

   task automatic stop_on_failure();
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      stop_on_failure();
   endtask

   task automatic check_byte(input string sig, input byte_t expected, input byte_t actual);
      assert (actual === expected)
      else
      begin
         $display("[FAIL] time %0t %s expected %02h actual %02h", $time, sig, expected, actual);
         stop_on_failure();
      end
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input byte_t data);
      @(posedge clk);
      req <= '{valid: 1'b1, we: 1'b1, addr: addr, wdata: data};
      // Visible to a read in the very next cycle
      apply_write_to_model(addr, data);
   endtask

   task automatic issue_read(input logic [ADDR_W-1:0] addr);
      byte_t value;
      bit    checkable;
      @(posedge clk);
      req <= '{valid: 1'b1, we: 1'b0, addr: addr, wdata: 8'h00};
      checkable = expected_read(addr, value);
      exp_q.push_back(value);
      chk_q.push_back(checkable);
   endtask

   task automatic idle_bus();
      @(posedge clk);
      req <= '0;
   endtask

   // Wait until every read in flight has answered
   task automatic drain_reads();
      int timer;
      timer = 0;
      idle_bus();
      while (exp_q.size() != 0)
      begin
         @(posedge clk);
         timer++;
         if (timer > 16)
            abort_run("Read responses stopped arriving before all reads were answered");
      end
   endtask

   // Counts are stable four cycles after the last pin change
   task automatic wait_pins_quiet();
      int timer;
      timer = 0;
      while (cyc - pin_cyc < 4)
      begin
         @(posedge clk);
         timer++;
         if (timer > 12)
            abort_run("Trackball pins never settled before the count reads");
      end
   endtask

   // One step per call on every axis, mode 0 down, 1 up, 2 random
   task automatic move_axes(input int steps, input int mode);
      logic [31:0] rnd;
      bit          move;
      bit          up;
      for (int s = 0; s < steps; s++)
      begin
         for (int ax = 0; ax < AXIS_COUNT; ax++)
         begin
            rnd  = next_rand();
            move = (mode != 2) || (rnd[1:0] != 2'b00);
            up   = (mode == 1) || (mode == 2 && rnd[2]);
            if (move && up)
            begin
               phase[ax]       = phase[ax] + 2'd1;
               count_model[ax] = count_model[ax] + 8'd1;
            end
            else if (move)
            begin
               phase[ax]       = phase[ax] - 2'd1;
               count_model[ax] = count_model[ax] - 8'd1;
            end
            trk_next[ax] = pins_for_phase(phase[ax]);
         end
         @(posedge clk);
         trk <= trk_next;
         pin_cyc = cyc;
         // At least 4 cycles between pin changes
         rnd = next_rand();
         repeat (3 + int'(rnd[1:0])) @(posedge clk);
      end
   endtask

   task automatic read_all_counts();
      wait_pins_quiet();
      for (int ax = 0; ax < AXIS_COUNT; ax++)
         issue_read(TRACK_BASE + ADDR_W'(ax));
      drain_reads();
   endtask

   // Response monitor, outputs sampled away from the driving edge
   always @(negedge clk)
   begin
      if (rsp.valid === 1'b1)
      begin
         assert (strobe_q.size() != 0)
         else abort_run("A response appeared with no read outstanding");
         strobe_t = strobe_q.pop_front();
         exp_v    = exp_q.pop_front();
         chk_v    = chk_q.pop_front();
         assert (cyc - strobe_t == READ_LATENCY)
         else abort_run("A response arrived at the wrong distance from its read strobe");
         if (chk_v)
            check_byte("rsp.rdata", exp_v, rsp.rdata);
      end
      if (req.valid && !req.we)
         strobe_q.push_back(cyc);
      cyc = cyc + 1;
   end

   initial
   begin
      logic [31:0]       rnd;
      logic [ADDR_W-1:0] addr;
      req      = '0;
      trk      = '0;
      trk_next = '0;
      reset_n  = 1'b0;
      for (int i = 0; i < NV_DEPTH; i++)
         nv_written[i] = 1'b0;
      for (int i = 0; i < COLOR_DEPTH; i++)
         color_written[i] = 1'b0;
      for (int i = 0; i < AXIS_COUNT; i++)
      begin
         count_model[i] = 8'h00;
         phase[i]       = 2'd0;
      end
      repeat (4) @(posedge clk);
      reset_n <= 1'b1;
      // Quiet bus, the monitor flags any stray response
      repeat (3) @(posedge clk);
      read_all_counts();

      // NVRAM mix, half the traffic on 16 hot cells so reads hit written data
      for (int n = 0; n < 300; n++)
      begin
         rnd  = next_rand();
         addr = rnd[1] ? {6'b0, rnd[11:8]} : {2'b0, rnd[15:8]};
         if (rnd[0])
            write_word(addr, rnd[23:16]);
         else
            issue_read(addr);
      end
      drain_reads();

      // Write then read the same cell in the next cycle
      for (int n = 0; n < 24; n++)
      begin
         rnd  = next_rand();
         addr = rnd[2] ? {2'b0, rnd[15:8]} : COLOR_BASE + {3'b0, rnd[14:8]};
         write_word(addr, rnd[23:16]);
         issue_read(addr);
      end
      drain_reads();

      // Color RAM through both aliases, then read every entry both ways
      for (int n = 0; n < 96; n++)
      begin
         rnd = next_rand();
         write_word(COLOR_BASE + {3'b0, rnd[6:0]}, rnd[15:8]);
      end
      for (int e = 0; e < COLOR_DEPTH; e++)
      begin
         issue_read(COLOR_BASE + ADDR_W'(e));
         issue_read(COLOR_BASE + ADDR_W'(e + 64));
      end
      drain_reads();

      // Trackball, wrap below 0 then above 255, then random bursts
      move_axes(20, 0);
      read_all_counts();
      move_axes(40, 1);
      read_all_counts();
      for (int r = 0; r < 4; r++)
      begin
         rnd = next_rand();
         move_axes(8 + int'(rnd[4:0]), 2);
         read_all_counts();
      end

      // Unmapped space both above the trackball and in the upper half
      for (int n = 0; n < 32; n++)
      begin
         rnd  = next_rand();
         addr = rnd[7] ? TRACK_BASE + 10'd4 + {3'b0, rnd[14:8]} : {1'b1, rnd[16:8]};
         issue_read(addr);
      end
      drain_reads();

      // Trackball writes are dropped
      for (int ax = 0; ax < AXIS_COUNT; ax++)
      begin
         rnd = next_rand();
         write_word(TRACK_BASE + ADDR_W'(ax), rnd[7:0]);
      end
      read_all_counts();

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* arcade_io.f */
arcade_io_pkg.sv
sync_ram.sv
quad_decoder.sv
leta_bank.sv
io_bus_ctrl.sv
arcade_io_top.sv
arcade_io_props.sv
arcade_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := arcade_io_tb
FILELIST  := arcade_io.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message is in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)
